//--- Bender.yml
package:
  name: radio_tx_core

export_include_dirs:
  - src

sources:
  - src/radio_pkg.sv
  - src/cmd_regs.sv
  - src/iq_serializer.sv
  - src/tx_keyer.sv
  - src/tx_assembler.sv
  - src/radio_tx_core.sv
  - target: test
    files:
      - testbench/tb_radio_tx_core.sv

//--- list.f
+incdir+src
src/radio_pkg.sv
src/cmd_regs.sv
src/iq_serializer.sv
src/tx_keyer.sv
src/tx_assembler.sv
src/radio_tx_core.sv
testbench/tb_radio_tx_core.sv

//--- src/cmd_regs.sv
/*
  Command register file on AXI4-Lite: control bits, version and status,
  and the IQ sample port with back-pressure from the serializer
*/
`timescale 1ns/1ps
`include "radio_cfg.svh"

module cmd_regs
  import radio_pkg::*;
(
  input  logic        clk_internal,
  input  logic        rst_n,
  input  axi_addr_t   s_axi_awaddr,
  input  logic        s_axi_awvalid,
  output logic        s_axi_awready,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0]  s_axi_wstrb,
  input  logic        s_axi_wvalid,
  output logic        s_axi_wready,
  output logic [1:0]  s_axi_bresp,
  output logic        s_axi_bvalid,
  input  logic        s_axi_bready,
  input  axi_addr_t   s_axi_araddr,
  input  logic        s_axi_arvalid,
  output logic        s_axi_arready,
  output logic [31:0] s_axi_rdata,
  output logic [1:0]  s_axi_rresp,
  output logic        s_axi_rvalid,
  input  logic        s_axi_rready,
  input  logic        iq_room,
  input  logic [4:0]  fifo_count,
  input  logic        tx_on,
  output logic        run,
  output logic        ptt,
  output logic        cwx_enable,
  output logic        iq_push,
  output logic [31:0] iq_word
);

  reg_addr_e   wr_addr;
  reg_addr_e   rd_addr;
  logic        wr_ready;
  logic        wr_take;
  logic        wr_fire;
  logic        ar_ready;
  logic        rd_fire;
  logic [2:0]  ctrl_q;
  logic [31:0] rd_mux;

  assign wr_addr = reg_addr_e'(s_axi_awaddr);
  assign rd_addr = reg_addr_e'(s_axi_araddr);

  // --------------------------------------------------
  // Write channel, AW and W taken together
  // --------------------------------------------------
  // IQ writes stall until the serializer has room for four bytes
  assign wr_take = s_axi_awvalid && s_axi_wvalid && !wr_ready && !s_axi_bvalid &&
                   ((wr_addr != REG_TX_IQ) || iq_room);
  assign wr_fire = wr_ready && s_axi_awvalid && s_axi_wvalid;

  assign s_axi_awready = wr_ready;
  assign s_axi_wready  = wr_ready;
  assign s_axi_bresp   = 2'b00;

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready     <= 1'b0;
      s_axi_bvalid <= 1'b0;
      iq_push      <= 1'b0;
      ctrl_q       <= 3'd0;
    end else begin
      wr_ready <= wr_take;
      iq_push  <= wr_fire && (wr_addr == REG_TX_IQ);
      if (wr_fire) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
      // Control bits all live in byte lane 0
      if (wr_fire && (wr_addr == REG_CONTROL) && s_axi_wstrb[0]) begin
        ctrl_q <= s_axi_wdata[2:0];
      end
    end
  end

  always_ff @(posedge clk_internal) begin
    if (wr_fire && (wr_addr == REG_TX_IQ)) begin
      iq_word <= s_axi_wdata;
    end
  end

  assign run        = ctrl_q[0];
  assign ptt        = ctrl_q[1];
  assign cwx_enable = ctrl_q[2];

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  always_comb begin
    case (rd_addr)
      REG_VERSION: rd_mux = {14'd0, `RADIO_FPGA_TYPE, `RADIO_VERSION_MAJOR, `RADIO_VERSION_MINOR};
      REG_CONTROL: rd_mux = {29'd0, ctrl_q};
      REG_STATUS:  rd_mux = {23'd0, tx_on, 3'd0, fifo_count};
      default:     rd_mux = 32'd0;
    endcase
  end

  assign rd_fire       = ar_ready && s_axi_arvalid;
  assign s_axi_arready = ar_ready;
  assign s_axi_rresp   = 2'b00;

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready     <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      ar_ready <= s_axi_arvalid && !ar_ready && !s_axi_rvalid;
      if (rd_fire) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_internal) begin
    if (rd_fire) begin
      s_axi_rdata <= rd_mux;
    end
  end

  // Room seen at acceptance must still hold when the push reaches the serializer
  assert property (@(posedge clk_internal) disable iff (!rst_n)
    iq_push |-> iq_room);

endmodule

//--- src/iq_serializer.sv
/*
  IQ serializer: splits each sample MSB first into a byte FIFO
  while push-to-talk or CW is enabled
*/
`timescale 1ns/1ps
`include "radio_cfg.svh"

module iq_serializer
  import radio_pkg::*;
(
  input  logic        clk_internal,
  input  logic        rst_n,
  input  logic        iq_push,
  input  logic [31:0] iq_word,
  input  logic        ptt,
  input  logic        cwx_enable,
  input  logic        byte_ready,
  output logic        iq_room,
  output logic [4:0]  fifo_count,
  output logic [7:0]  byte_data,
  output logic        byte_valid,
  output logic        byte_last
);

  localparam int DEPTH = `RADIO_DSIQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] ROOM_MAX = (PTR_W + 1)'(DEPTH - 4);

  ser_state_e       state;
  logic [1:0]       byte_idx;
  logic [31:0]      word_q;
  iq_byte_t         wr_byte;
  logic             wr_en;
  logic             rd_en;
  logic [8:0]       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // --------------------------------------------------
  // Byte split FSM
  // --------------------------------------------------
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      state    <= SER_START;
      byte_idx <= 2'd3;
    end else begin
      case (state)
        SER_START: begin
          byte_idx <= 2'd3;
          // Samples outside PTT or CW are dropped here
          if (iq_push && (ptt || cwx_enable)) begin
            state <= SER_TX_DATA;
          end
        end
        SER_TX_DATA: begin
          byte_idx <= byte_idx - 2'd1;
          if (byte_idx == 2'd0) begin
            state <= SER_START;
          end
        end
        default: state <= SER_START;
      endcase
    end
  end

  always_ff @(posedge clk_internal) begin
    if ((state == SER_START) && iq_push) begin
      word_q <= iq_word;
    end
  end

  assign wr_en   = (state == SER_TX_DATA);
  assign wr_byte = word_q[8*byte_idx +: 8];

  // --------------------------------------------------
  // Circular byte FIFO, bit 8 flags the last byte
  // --------------------------------------------------
  assign rd_en = byte_valid && byte_ready;

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_internal) begin
    if (wr_en) begin
      mem[wr_ptr] <= {(byte_idx == 2'd0), wr_byte};
    end
  end

  assign byte_valid = (count != '0);
  assign byte_data  = mem[rd_ptr][7:0];
  assign byte_last  = mem[rd_ptr][8];
  assign fifo_count = count;
  assign iq_room    = (state == SER_START) && (count <= ROOM_MAX);

  // Relies on cmd_regs holding writes back until four bytes are free
  assert property (@(posedge clk_internal) disable iff (!rst_n)
    wr_en |-> (count < DEPTH));
  // Equal pointers mean empty unless the count says full
  assert property (@(posedge clk_internal) disable iff (!rst_n)
    rd_en |-> ((wr_ptr != rd_ptr) || count[PTR_W]));

endmodule

//--- src/radio_cfg.svh
/*
  Radio TX core configuration: register map, version word,
  byte FIFO depth and key timing
*/
`ifndef RADIO_CFG_SVH
`define RADIO_CFG_SVH

// Register map, byte addresses
`define RADIO_AXI_AW        4
`define RADIO_REG_VERSION   4'h0
`define RADIO_REG_CONTROL   4'h4
`define RADIO_REG_TX_IQ     4'h8
`define RADIO_REG_STATUS    4'hC

// Version word fields
`define RADIO_VERSION_MAJOR 8'd73
`define RADIO_VERSION_MINOR 8'd2
`define RADIO_FPGA_TYPE     2'd2

// Byte FIFO depth, power of two
`define RADIO_DSIQ_DEPTH    16

// Key timing in clk_internal cycles
`define RADIO_KEY_DEBOUNCE  8
`define RADIO_KEY_HANG      32

`endif

//--- src/radio_pkg.sv
/*
  Shared types of the radio TX core: bus words, register map, FSM states
*/
`include "radio_cfg.svh"

package radio_pkg;

  typedef logic [`RADIO_AXI_AW-1:0] axi_addr_t;
  typedef logic [31:0]              iq_word_t;
  typedef logic [7:0]               iq_byte_t;

  typedef enum logic [`RADIO_AXI_AW-1:0] {
    REG_VERSION = `RADIO_REG_VERSION,
    REG_CONTROL = `RADIO_REG_CONTROL,
    REG_TX_IQ   = `RADIO_REG_TX_IQ,
    REG_STATUS  = `RADIO_REG_STATUS
  } reg_addr_e;

  // IQ serializer, idle or writing four bytes
  typedef enum logic {
    SER_START,
    SER_TX_DATA
  } ser_state_e;

  typedef enum logic [1:0] {
    KEY_IDLE,
    KEY_DEBOUNCE,
    KEY_KEYED,
    KEY_HANG
  } key_state_e;

endpackage

//--- src/radio_tx_core.sv
/*
  Radio TX core top: command registers, IQ serializer, keyer, assembler
*/
`timescale 1ns/1ps

module radio_tx_core
  import radio_pkg::*;
(
  input  logic        clk_internal,
  input  logic        rst_n,
  input  axi_addr_t   s_axi_awaddr,
  input  logic        s_axi_awvalid,
  output logic        s_axi_awready,
  input  logic [31:0] s_axi_wdata,
  input  logic [3:0]  s_axi_wstrb,
  input  logic        s_axi_wvalid,
  output logic        s_axi_wready,
  output logic [1:0]  s_axi_bresp,
  output logic        s_axi_bvalid,
  input  logic        s_axi_bready,
  input  axi_addr_t   s_axi_araddr,
  input  logic        s_axi_arvalid,
  output logic        s_axi_arready,
  output logic [31:0] s_axi_rdata,
  output logic [1:0]  s_axi_rresp,
  output logic        s_axi_rvalid,
  input  logic        s_axi_rready,
  input  logic        io_phone_tip,
  output logic [31:0] tx_iq_data,
  output logic        tx_cw,
  output logic        tx_iq_valid,
  input  logic        tx_iq_ready,
  output logic        cw_on
);

  logic        run;
  logic        ptt;
  logic        cwx_enable;
  logic        iq_push;
  logic [31:0] iq_word;
  logic        iq_room;
  logic [4:0]  fifo_count;
  logic        tx_on;
  logic [7:0]  byte_data;
  logic        byte_valid;
  logic        byte_ready;
  logic        byte_last;

  // --------------------------------------------------
  // Host side
  // --------------------------------------------------
  cmd_regs cmd_regs_i (
    .clk_internal  (clk_internal),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .iq_room       (iq_room),
    .fifo_count    (fifo_count),
    .tx_on         (tx_on),
    .run           (run),
    .ptt           (ptt),
    .cwx_enable    (cwx_enable),
    .iq_push       (iq_push),
    .iq_word       (iq_word)
  );

  // --------------------------------------------------
  // Transmit path
  // --------------------------------------------------
  iq_serializer iq_serializer_i (
    .clk_internal (clk_internal),
    .rst_n        (rst_n),
    .iq_push      (iq_push),
    .iq_word      (iq_word),
    .ptt          (ptt),
    .cwx_enable   (cwx_enable),
    .byte_ready   (byte_ready),
    .iq_room      (iq_room),
    .fifo_count   (fifo_count),
    .byte_data    (byte_data),
    .byte_valid   (byte_valid),
    .byte_last    (byte_last)
  );

  tx_keyer tx_keyer_i (
    .clk_internal (clk_internal),
    .rst_n        (rst_n),
    .io_phone_tip (io_phone_tip),
    .run          (run),
    .ptt          (ptt),
    .cwx_enable   (cwx_enable),
    .tx_on        (tx_on),
    .cw_on        (cw_on)
  );

  tx_assembler tx_assembler_i (
    .clk_internal (clk_internal),
    .rst_n        (rst_n),
    .byte_data    (byte_data),
    .byte_valid   (byte_valid),
    .byte_last    (byte_last),
    .cwx_enable   (cwx_enable),
    .tx_on        (tx_on),
    .tx_iq_ready  (tx_iq_ready),
    .byte_ready   (byte_ready),
    .tx_iq_data   (tx_iq_data),
    .tx_cw        (tx_cw),
    .tx_iq_valid  (tx_iq_valid)
  );

endmodule

//--- src/tx_assembler.sv
/*
  TX assembler: rebuilds IQ words from FIFO bytes, adds the CW flag
  and releases words toward the DAC side while transmitting
*/
`timescale 1ns/1ps

module tx_assembler
  import radio_pkg::*;
(
  input  logic        clk_internal,
  input  logic        rst_n,
  input  logic [7:0]  byte_data,
  input  logic        byte_valid,
  input  logic        byte_last,
  input  logic        cwx_enable,
  input  logic        tx_on,
  input  logic        tx_iq_ready,
  output logic        byte_ready,
  output logic [31:0] tx_iq_data,
  output logic        tx_cw,
  output logic        tx_iq_valid
);

  iq_word_t word_q;
  logic     held;
  logic     cw_acc;
  logic     cw_q;
  logic     valid_q;
  logic     pop;
  logic     last_pop;
  logic     xfer;

  // No pops while a finished word waits
  assign byte_ready = !held;
  assign pop        = byte_valid && byte_ready;
  assign last_pop   = pop && byte_last;
  assign xfer       = valid_q && tx_iq_ready;

  // MSB arrives first
  always_ff @(posedge clk_internal) begin
    if (pop) begin
      word_q <= {word_q[23:0], byte_data};
    end
  end

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      held    <= 1'b0;
      cw_acc  <= 1'b0;
      cw_q    <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (last_pop) begin
        held   <= 1'b1;
        cw_acc <= 1'b0;
        cw_q   <= (cw_acc | byte_data[0]) & cwx_enable;
      end else if (pop) begin
        cw_acc <= cw_acc | byte_data[0];
      end
      // Once raised, valid stays up until taken even if tx_on drops
      if (xfer) begin
        held    <= 1'b0;
        valid_q <= 1'b0;
      end else if (tx_on && (held || last_pop)) begin
        valid_q <= 1'b1;
      end
    end
  end

  assign tx_iq_data  = word_q;
  assign tx_cw       = cw_q;
  assign tx_iq_valid = valid_q;

  assert property (@(posedge clk_internal) disable iff (!rst_n)
    tx_iq_valid && !tx_iq_ready |=> tx_iq_valid && $stable(tx_iq_data) && $stable(tx_cw));

endmodule

//--- src/tx_keyer.sv
/*
  Transmit keyer: debounces the key, holds a hang time after release
  and decides tx_on and cw_on
*/
`timescale 1ns/1ps
`include "radio_cfg.svh"

module tx_keyer
  import radio_pkg::*;
(
  input  logic clk_internal,
  input  logic rst_n,
  input  logic io_phone_tip,
  input  logic run,
  input  logic ptt,
  input  logic cwx_enable,
  output logic tx_on,
  output logic cw_on
);

  localparam int CNT_W = $clog2(`RADIO_KEY_HANG + `RADIO_KEY_DEBOUNCE);
  localparam logic [CNT_W-1:0] DEB_LAST  = CNT_W'(`RADIO_KEY_DEBOUNCE - 1);
  localparam logic [CNT_W-1:0] HANG_LAST = CNT_W'(`RADIO_KEY_HANG - 1);

  key_state_e       state;
  logic [1:0]       key_sync;
  logic             key_down;
  logic [CNT_W-1:0] cnt;
  logic             keyed;

  // Key line idles high, so the synchronizer resets to released
  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      key_sync <= 2'b11;
    end else begin
      key_sync <= {key_sync[0], io_phone_tip};
    end
  end

  assign key_down = !key_sync[1];

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      state <= KEY_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        KEY_IDLE: begin
          // First low sample already counts toward the debounce
          if (key_down) begin
            state <= KEY_DEBOUNCE;
            cnt   <= CNT_W'(1);
          end
        end
        KEY_DEBOUNCE: begin
          if (!key_down) begin
            state <= KEY_IDLE;
          end else if (cnt == DEB_LAST) begin
            state <= KEY_KEYED;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        KEY_KEYED: begin
          if (!key_down) begin
            state <= KEY_HANG;
            cnt   <= '0;
          end
        end
        KEY_HANG: begin
          if (key_down) begin
            state <= KEY_KEYED;
          end else if (cnt == HANG_LAST) begin
            state <= KEY_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= KEY_IDLE;
      endcase
    end
  end

  assign keyed = (state == KEY_KEYED) || (state == KEY_HANG);

  always_ff @(posedge clk_internal or negedge rst_n) begin
    if (!rst_n) begin
      tx_on <= 1'b0;
      cw_on <= 1'b0;
    end else begin
      tx_on <= run && (ptt || keyed);
      cw_on <= keyed && cwx_enable;
    end
  end

endmodule

//--- testbench/tb_radio_tx_core.sv
/*
  Directed testbench for the radio TX core: AXI4-Lite host tasks,
  IQ word checking against a reference queue, keyer timing
*/
`timescale 1ns/1ps

module tb_radio_tx_core
  import radio_pkg::*;
;

  localparam int TEST_COUNT = 6;
  localparam int HS_LIMIT   = 1000;

  logic        clk_internal;
  logic        rst_n;
  logic [3:0]  s_axi_awaddr;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0]  s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  logic [1:0]  s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  logic [3:0]  s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0]  s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;
  logic        io_phone_tip;
  logic [31:0] tx_iq_data;
  logic        tx_cw;
  logic        tx_iq_valid;
  logic        tx_iq_ready;
  logic        cw_on;

  logic [15:0] lfsr_state;
  logic [31:0] exp_data[$];
  logic        exp_cw[$];
  logic [31:0] got_data[$];
  logic        got_cw[$];
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          writes_done;

  radio_tx_core radio_tx_core_i (
    .clk_internal  (clk_internal),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .io_phone_tip  (io_phone_tip),
    .tx_iq_data    (tx_iq_data),
    .tx_cw         (tx_cw),
    .tx_iq_valid   (tx_iq_valid),
    .tx_iq_ready   (tx_iq_ready),
    .cw_on         (cw_on)
  );

  initial begin
    clk_internal = 1'b0;
    forever #20 clk_internal = ~clk_internal;
  end

  // Output monitor, a transfer happens at the next rising edge
  always @(negedge clk_internal) begin
    if (rst_n && tx_iq_valid && tx_iq_ready) begin
      got_data.push_back(tx_iq_data);
      got_cw.push_back(tx_cw);
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic next_sample(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // CW flag is the OR of bit 0 of all four bytes when enabled
  function automatic logic expected_cw(logic [31:0] w, logic cwx);
    return (w[24] | w[16] | w[8] | w[0]) & cwx;
  endfunction

  task automatic report_value(string sig, logic [31:0] got, logic [31:0] exp);
    $display("FAIL %s: got 0x%08h, expected 0x%08h", sig, got, exp);
    errors++;
  endtask

  task automatic report_problem(string what);
    $display("Error: %s", what);
    errors++;
  endtask

  task automatic axi_write(logic [3:0] addr, logic [31:0] data);
    int n;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = 4'hF;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    n = 0;
    do begin
      @(negedge clk_internal);
      n++;
    end while (!(s_axi_awready && s_axi_wready) && n < HS_LIMIT);
    if (n >= HS_LIMIT) begin
      report_problem("AXI write address/data handshake never completed");
    end
    @(posedge clk_internal);
    #2;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    do begin
      @(negedge clk_internal);
      n++;
    end while (!s_axi_bvalid && n < HS_LIMIT);
    if (n >= HS_LIMIT) begin
      report_problem("AXI write response never arrived");
    end
    if (s_axi_bresp != 2'b00) begin
      report_value("s_axi_bresp", s_axi_bresp, 0);
    end
    @(posedge clk_internal);
    #2;
  endtask

  task automatic axi_read(logic [3:0] addr, output logic [31:0] data);
    int n;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk_internal);
      n++;
    end while (!s_axi_arready && n < HS_LIMIT);
    if (n >= HS_LIMIT) begin
      report_problem("AXI read address handshake never completed");
    end
    @(posedge clk_internal);
    #2;
    s_axi_arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk_internal);
      n++;
    end while (!s_axi_rvalid && n < HS_LIMIT);
    if (n >= HS_LIMIT) begin
      report_problem("AXI read data never arrived");
    end
    if (s_axi_rresp != 2'b00) begin
      report_value("s_axi_rresp", s_axi_rresp, 0);
    end
    data = s_axi_rdata;
    @(posedge clk_internal);
    #2;
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk_internal);
    #2;
  endtask

  // Writes samples to REG_TX_IQ and records what the DAC side must see
  task automatic write_samples(int n, logic cwx);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      next_sample(w);
      exp_data.push_back(w);
      exp_cw.push_back(expected_cw(w, cwx));
      axi_write(REG_TX_IQ, w);
      writes_done++;
    end
  endtask

  task automatic wait_words(int n);
    int c;
    c = 0;
    while (got_data.size() < n && c < 400) begin
      @(posedge clk_internal);
      #2;
      c++;
    end
    if (got_data.size() < n) begin
      report_problem($sformatf("only %0d of %0d IQ words came out", got_data.size(), n));
    end
  endtask

  task automatic compare_words();
    logic [31:0] d;
    logic        f;
    while (exp_data.size() > 0) begin
      d = exp_data.pop_front();
      f = exp_cw.pop_front();
      if (got_data.size() == 0) begin
        report_problem("expected IQ word is missing on the output");
      end else begin
        if (got_data[0] !== d) begin
          report_value("tx_iq_data", got_data[0], d);
        end
        if (got_cw[0] !== f) begin
          report_value("tx_cw", got_cw[0], f);
        end
        void'(got_data.pop_front());
        void'(got_cw.pop_front());
      end
    end
    if (got_data.size() != 0) begin
      report_problem($sformatf("%0d unexpected IQ words on the output", got_data.size()));
      got_data.delete();
      got_cw.delete();
    end
  endtask

  task automatic test_done(string name, int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("[%0t] test %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] test %s: %0d check(s) failed", $time, name, errors - errs_at_start);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset_identity();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    if (tx_iq_valid !== 1'b0) begin
      report_value("tx_iq_valid", tx_iq_valid, 0);
    end
    if (cw_on !== 1'b0) begin
      report_value("cw_on", cw_on, 0);
    end
    axi_read(REG_STATUS, rd);
    if (rd !== 32'h0) begin
      report_value("status", rd, 32'h0);
    end
    axi_read(REG_VERSION, rd);
    if (rd !== 32'h00024902) begin
      report_value("version", rd, 32'h00024902);
    end
    test_done("reset_identity", e0);
  endtask

  task automatic test_control_reg();
    int          e0;
    logic [31:0] rd;
    logic [31:0] exp_status;
    e0 = errors;
    for (int v = 0; v < 8; v++) begin
      axi_write(REG_CONTROL, v);
      axi_read(REG_CONTROL, rd);
      if (rd !== v) begin
        report_value("control", rd, v);
      end
      // tx_on needs run and ptt, the key is idle
      exp_status = (v[0] && v[1]) ? 32'h100 : 32'h0;
      axi_read(REG_STATUS, rd);
      if (rd !== exp_status) begin
        report_value("status", rd, exp_status);
      end
    end
    axi_write(REG_CONTROL, 0);
    test_done("control_reg", e0);
  endtask

  task automatic test_iq_transfer();
    int e0;
    e0 = errors;
    axi_write(REG_CONTROL, 32'h3);
    write_samples(5, 1'b0);
    wait_words(5);
    compare_words();
    axi_write(REG_CONTROL, 32'h7);
    write_samples(5, 1'b1);
    wait_words(5);
    compare_words();
    axi_write(REG_CONTROL, 0);
    test_done("iq_transfer", e0);
  endtask

  task automatic test_gating();
    int          e0;
    logic [31:0] w;
    logic [31:0] rd;
    e0 = errors;
    // Run only, the sample must be dropped
    axi_write(REG_CONTROL, 32'h1);
    next_sample(w);
    axi_write(REG_TX_IQ, w);
    wait_cycles(20);
    axi_read(REG_STATUS, rd);
    if (rd !== 32'h0) begin
      report_value("status", rd, 32'h0);
    end
    // Keying up afterwards would release a sample that was not dropped
    axi_write(REG_CONTROL, 32'h3);
    wait_cycles(20);
    if (got_data.size() != 0) begin
      report_problem("sample written without ptt or CW reached the output");
    end
    // PTT without run holds the word
    axi_write(REG_CONTROL, 32'h2);
    write_samples(1, 1'b0);
    wait_cycles(20);
    if (tx_iq_valid !== 1'b0) begin
      report_value("tx_iq_valid", tx_iq_valid, 0);
    end
    axi_write(REG_CONTROL, 32'h3);
    wait_words(1);
    compare_words();
    axi_write(REG_CONTROL, 0);
    test_done("gating", e0);
  endtask

  task automatic test_back_pressure();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    axi_write(REG_CONTROL, 32'h3);
    tx_iq_ready = 1'b0;
    writes_done = 0;
    fork
      write_samples(8, 1'b0);
    join_none
    for (int i = 0; i < 40; i++) begin
      axi_read(REG_STATUS, rd);
      if (rd[4:0] > 5'd16) begin
        report_value("fifo_count", rd[4:0], 16);
      end
    end
    if (writes_done >= 8) begin
      report_problem("IQ writes were not held back while tx_iq_ready was low");
    end
    tx_iq_ready = 1'b1;
    wait_words(8);
    wait (writes_done == 8);
    wait_cycles(1);
    compare_words();
    axi_write(REG_CONTROL, 0);
    test_done("back_pressure", e0);
  endtask

  task automatic test_key_hang();
    int e0;
    int cycles;
    int on_at;
    int cw_at;
    int off_at;
    e0 = errors;
    // CW enabled so cw_on follows the key as well
    axi_write(REG_CONTROL, 32'h5);
    io_phone_tip = 1'b0;
    cycles = 0;
    on_at  = 0;
    cw_at  = 0;
    while (cycles < 20) begin
      @(negedge clk_internal);
      cycles++;
      if (on_at == 0 && radio_tx_core_i.tx_on) begin
        on_at = cycles;
      end
      if (cw_at == 0 && cw_on === 1'b1) begin
        cw_at = cycles;
      end
    end
    if (on_at == 0 || on_at > 12) begin
      report_problem($sformatf("tx_on did not rise within 12 cycles of key press (%0d)", on_at));
    end
    if (cw_at == 0 || cw_at > 12) begin
      report_problem($sformatf("cw_on did not rise within 12 cycles of key press (%0d)", cw_at));
    end
    @(posedge clk_internal);
    #2;
    io_phone_tip = 1'b1;
    cycles = 0;
    off_at = 0;
    while (cycles < 44 && off_at == 0) begin
      @(negedge clk_internal);
      cycles++;
      if (!radio_tx_core_i.tx_on) begin
        off_at = cycles;
      end
    end
    if (off_at == 0) begin
      report_problem("tx_on still high 44 cycles after key release");
    end else if (off_at <= 32) begin
      report_problem($sformatf("tx_on dropped %0d cycles after release, hang too short", off_at));
    end
    @(posedge clk_internal);
    #2;
    axi_write(REG_CONTROL, 0);
    test_done("key_hang", e0);
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst_n         = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    io_phone_tip  = 1'b1;
    tx_iq_ready   = 1'b1;
    lfsr_state    = 16'd7145;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    writes_done   = 0;
    repeat (5) @(posedge clk_internal);
    #2;
    rst_n = 1'b1;

    test_reset_identity();
    test_control_reg();
    test_iq_transfer();
    test_gating();
    test_back_pressure();
    test_key_hang();

    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (TEST_COUNT * 2000) @(posedge clk_internal);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule
